//--- logic/st_glue_pkg.sv
// shared widths, enums, request structs and video base constants for the st glue logic
package st_glue_pkg;

	localparam int ADDR_W = 23;	// word address, bits 23..1

	// ram size code from control bits 3..1
	typedef enum logic [2:0] {
		MEM_512K = 3'd0,
		MEM_1M   = 3'd1,
		MEM_2M   = 3'd2,
		MEM_4M   = 3'd3,
		MEM_8M   = 3'd4,
		MEM_14M  = 3'd5
	} mem_size_e;

	// bus slot as seen by the sdram port
	typedef enum logic [1:0] {
		SLOT_PRE   = 2'd0,	// cpu precycle
		SLOT_CPU   = 2'd1,
		SLOT_VIDEO = 2'd2	// shifter or viking fetch
	} bus_slot_e;

	typedef struct packed {
		mem_size_e mem_size;
		logic      ste;
		logic      mste;
		logic      steroids;	// ste and mste together
		logic      psg_stereo;
		logic      blitter_en;
		logic      viking_en;
	} cfg_t;

	typedef struct packed {
		logic [ADDR_W-1:0] addr;
		logic [15:0]       din;
		logic              oe;
		logic              we;
		logic              uds;
		logic              lds;
	} ram_req_t;

	typedef struct packed {
		logic [ADDR_W-1:0] addr;
		logic [15:0]       data;
	} dl_word_t;

	// blitter bus master side
	typedef struct packed {
		logic [ADDR_W-1:0] addr;
		logic [15:0]       data;
		logic              read;
		logic              write;
		logic              has_bus;
	} bm_req_t;

	// raw chipset strobes, already ras qualified
	typedef struct packed {
		logic [ADDR_W-1:0] addr;
		logic [15:0]       din;
		logic              oe;
		logic              we;
		logic              uds;
		logic              lds;
	} chip_req_t;

	typedef struct packed {
		logic [7:0] a;
		logic [7:0] b;
		logic [7:0] c;
	} ym_chan_t;

	// address bits 23..18 of the viking frame buffer
	localparam logic [5:0] VIKING_BASE_LO = 6'b110000;	// $c00000
	localparam logic [5:0] VIKING_BASE_HI = 6'b111010;	// $e80000, steroids

endpackage

//--- logic/sys_config.sv
// registered decode of the io controller control word into configuration fields
`timescale 1ns/1ps

module sys_config (
	input  logic              clk_32,
	input  logic              xsint,
	input  logic [31:0]       ctrl_i,	// from io controller
	output st_glue_pkg::cfg_t cfg_o
);

	st_glue_pkg::cfg_t cfg_d;
	logic              ste_d;
	logic              steroids_d;
	logic              mem_ok;

	assign ste_d      = ctrl_i[23] | ctrl_i[24];
	assign steroids_d = ctrl_i[23] & ctrl_i[24];	// ste on steroids

	// viking needs the top of the map free, 8M or less
	assign mem_ok = (st_glue_pkg::mem_size_e'(ctrl_i[3:1]) <= st_glue_pkg::MEM_8M);

	always_comb begin
		cfg_d.mem_size   = st_glue_pkg::mem_size_e'(ctrl_i[3:1]);
		cfg_d.ste        = ste_d;
		cfg_d.mste       = ctrl_i[24];
		cfg_d.steroids   = steroids_d;
		cfg_d.psg_stereo = ctrl_i[22];
		cfg_d.blitter_en = ctrl_i[19] | ste_d;	// ste always has one
		// steroids moves video to $e80000 so any size is fine there
		cfg_d.viking_en  = (ctrl_i[28] & mem_ok) | steroids_d;
	end

	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			cfg_o <= '0;	// 512k plain st
		end else begin
			cfg_o <= cfg_d;
		end
	end

endmodule

//--- logic/sdram_arbiter.sv
// slot based sdram request select, download handshake, ram window and tos tracking
`timescale 1ns/1ps

module sdram_arbiter (
	input  logic                             clk_32,
	input  logic                             xsint,
	input  st_glue_pkg::cfg_t                cfg_i,
	input  st_glue_pkg::bus_slot_e           slot_i,
	input  logic                             slot_en_i,
	input  st_glue_pkg::chip_req_t           chip_req_i,
	input  st_glue_pkg::bm_req_t             bm_i,
	input  st_glue_pkg::dl_word_t            dl_i,
	input  logic                             dl_valid_i,
	input  logic                             download_i,
	input  logic                             vik_read_i,
	input  logic [st_glue_pkg::ADDR_W-1:0]   vik_addr_i,
	input  logic                             viking_active_i,
	input  logic [st_glue_pkg::ADDR_W-1:0]   cpu_addr_i,
	input  logic                             rom2_sel_i,
	output logic                             dl_ready_o,
	output st_glue_pkg::ram_req_t            ram_req_o,
	output logic [st_glue_pkg::ADDR_W-1:0]   rom_addr_o
);

	logic                           cpu_slot;
	logic                           dl_slot;
	logic                           bm_slot;
	logic                           vik_fetch;
	logic                           dl_fire;
	logic                           ram_en;
	st_glue_pkg::ram_req_t          req_d;
	logic                           oe_q;
	logic                           we_q;
	logic [st_glue_pkg::ADDR_W-1:0] addr_q;
	logic [15:0]                    din_q;
	logic                           uds_q;
	logic                           lds_q;
	logic                           tos192k;

	assign cpu_slot   = (slot_i == st_glue_pkg::SLOT_CPU);
	assign dl_slot    = cpu_slot & download_i;
	assign bm_slot    = cpu_slot & ~download_i & bm_i.has_bus;	// download wins
	assign vik_fetch  = (slot_i == st_glue_pkg::SLOT_VIDEO) & viking_active_i & vik_read_i;
	assign dl_ready_o = slot_en_i & dl_slot;
	assign dl_fire    = dl_ready_o & dl_valid_i;	// word taken

	// ram window per size code with addr[22] as address bit 23
	always_comb begin
		case (cfg_i.mem_size)
			st_glue_pkg::MEM_512K: ram_en = (chip_req_i.addr[22:18] == 5'b00000);
			st_glue_pkg::MEM_1M:   ram_en = (chip_req_i.addr[22:19] == 4'b0000);
			st_glue_pkg::MEM_2M:   ram_en = (chip_req_i.addr[22:20] == 3'b000);
			st_glue_pkg::MEM_4M:   ram_en = (chip_req_i.addr[22:21] == 2'b00);
			st_glue_pkg::MEM_8M:   ram_en = ~chip_req_i.addr[22];
			st_glue_pkg::MEM_14M:  ram_en = ~&chip_req_i.addr[22:20];	// io at $e00000 up
			default:               ram_en = 1'b0;
		endcase
	end

	always_comb begin
		// chipset by default and a write masks a stray read strobe
		req_d.addr = chip_req_i.addr;
		req_d.oe   = chip_req_i.oe & ~chip_req_i.we & ram_en & (|chip_req_i.addr);
		req_d.we   = chip_req_i.we & ram_en;
		req_d.uds  = chip_req_i.uds;
		req_d.lds  = chip_req_i.lds;
		if (dl_slot) begin
			req_d.addr = dl_i.addr;
			req_d.oe   = 1'b0;
			req_d.we   = dl_fire;	// idle slot if no word
			req_d.uds  = 1'b1;
			req_d.lds  = 1'b1;
		end else if (bm_slot) begin
			req_d.addr = bm_i.addr;
			req_d.oe   = bm_i.read & ~bm_i.write;
			req_d.we   = bm_i.write;
			req_d.uds  = 1'b1;
			req_d.lds  = 1'b1;
		end else if (vik_fetch) begin
			req_d.addr = vik_addr_i;	// card frame buffer fetch
			req_d.oe   = 1'b1;
			req_d.we   = 1'b0;
		end
		// write data follows the bus owner and not the slot
		if (download_i) begin
			req_d.din = dl_i.data;
		end else if (bm_i.has_bus) begin
			req_d.din = bm_i.data;
		end else begin
			req_d.din = chip_req_i.din;
		end
	end

	// strobes last exactly one cycle after the slot
	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			oe_q <= 1'b0;
			we_q <= 1'b0;
		end else begin
			oe_q <= slot_en_i & req_d.oe;
			we_q <= slot_en_i & req_d.we;
		end
	end

	always_ff @(posedge clk_32) begin
		if (slot_en_i) begin
			addr_q <= req_d.addr;
			din_q  <= req_d.din;
			uds_q  <= req_d.uds;
			lds_q  <= req_d.lds;
		end
	end

	always_comb begin
		ram_req_o.addr = addr_q;
		ram_req_o.din  = din_q;
		ram_req_o.oe   = oe_q;
		ram_req_o.we   = we_q;
		ram_req_o.uds  = uds_q;
		ram_req_o.lds  = lds_q;
	end

	// 192k tos loads at $fc0000, 256k tos at $e00000
	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			tos192k <= 1'b0;
		end else if (dl_fire) begin
			if (dl_i.addr[22:17] == 6'b111111) begin
				tos192k <= 1'b1;
			end else if (dl_i.addr[22:19] == 4'he) begin
				tos192k <= 1'b0;
			end
		end
	end

	always_comb begin
		rom_addr_o = cpu_addr_i;
		if (rom2_sel_i) begin
			rom_addr_o[22:17] = tos192k ? 6'b111111 : 6'b111000;	// $fc or $e0
		end
	end

endmodule

//--- logic/viking_detect.sv
// counter of cpu hits on the viking frame buffer and the driver active flag
`timescale 1ns/1ps

module viking_detect #(
	parameter int VIKING_CNT_W = 8
) (
	input  logic                           clk_32,
	input  logic                           xsint,
	input  st_glue_pkg::cfg_t              cfg_i,
	input  logic                           slot_en_i,
	input  logic                           cpu_as_i,
	input  logic [st_glue_pkg::ADDR_W-1:0] cpu_addr_i,
	output logic                           viking_active_o
);

	logic [VIKING_CNT_W-1:0] use_cnt;
	logic [5:0]              base;
	logic                    hit;
	logic                    cnt_full;

	// steroids moves the card to $e80000
	assign base = cfg_i.steroids ? st_glue_pkg::VIKING_BASE_HI : st_glue_pkg::VIKING_BASE_LO;

	// only a driver hits it often where a few probes are normal
	assign hit      = slot_en_i & cpu_as_i & cfg_i.viking_en & (cpu_addr_i[22:17] == base);
	assign cnt_full = &use_cnt;

	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			use_cnt         <= '0;
			viking_active_o <= 1'b0;
		end else begin
			if (hit && !cnt_full) begin
				use_cnt <= use_cnt + 1'b1;	// saturates
			end
			if (cnt_full) begin
				viking_active_o <= 1'b1;	// sticky until reset
			end
		end
	end

endmodule

//--- logic/audio_mix.sv
// ym channel sums and dma sound widened to 15 bits and added per side
`timescale 1ns/1ps

module audio_mix (
	input  logic                  clk_32,
	input  logic                  xsint,
	input  st_glue_pkg::cfg_t     cfg_i,
	input  st_glue_pkg::ym_chan_t ym_i,
	input  logic [7:0]            ste_l_i,
	input  logic [7:0]            ste_r_i,
	output logic [14:0]           audio_l_o,
	output logic [14:0]           audio_r_o
);

	logic [9:0] ym_a;
	logic [9:0] ym_b;
	logic [9:0] ym_c;
	logic [9:0] ym_l;
	logic [9:0] ym_r;

	// unsigned ym sum to signed, then scaled up by repeating top bits
	function automatic logic [14:0] widen_ym(input logic [9:0] sum);
		logic [9:0] s;
		s = sum - 10'h200;
		return {s[9], s, s[9:6]};
	endfunction

	// dma sample is offset binary around $80
	function automatic logic [14:0] widen_dma(input logic [7:0] smp);
		logic [7:0] s;
		s = smp - 8'h80;
		return {s[7], s, s[7:2]};
	endfunction

	assign ym_a = {2'b00, ym_i.a};
	assign ym_b = {2'b00, ym_i.b};
	assign ym_c = {2'b00, ym_i.c};

	// stereo puts a left, c right, b in the middle
	assign ym_l = cfg_i.psg_stereo ? (ym_a + ym_b) : (ym_a + ym_b + ym_c);
	assign ym_r = cfg_i.psg_stereo ? (ym_c + ym_b) : (ym_a + ym_b + ym_c);

	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			audio_l_o <= '0;
			audio_r_o <= '0;
		end else begin
			audio_l_o <= widen_ym(ym_l) + widen_dma(ste_l_i);	// wraps mod 2^15
			audio_r_o <= widen_ym(ym_r) + widen_dma(ste_r_i);
		end
	end

endmodule

//--- logic/st_glue_top.sv
// top level wiring of config decode, sdram arbiter, viking detect and audio mixer
`timescale 1ns/1ps

module st_glue_top #(
	parameter int VIKING_CNT_W = 8	// accesses before viking takes over
) (
	input  logic                           clk_32,
	input  logic                           xsint,
	input  logic [31:0]                    ctrl_i,
	input  st_glue_pkg::bus_slot_e         slot_i,
	input  logic                           slot_en_i,
	input  st_glue_pkg::chip_req_t         chip_req_i,
	input  st_glue_pkg::bm_req_t           bm_i,
	input  st_glue_pkg::dl_word_t          dl_i,
	input  logic                           dl_valid_i,
	input  logic                           download_i,
	output logic                           dl_ready_o,
	input  logic                           cpu_as_i,
	input  logic [st_glue_pkg::ADDR_W-1:0] cpu_addr_i,
	input  logic                           rom2_sel_i,
	input  logic                           vik_read_i,
	input  logic [st_glue_pkg::ADDR_W-1:0] vik_addr_i,
	input  st_glue_pkg::ym_chan_t          ym_i,
	input  logic [7:0]                     ste_l_i,
	input  logic [7:0]                     ste_r_i,
	output st_glue_pkg::ram_req_t          ram_req_o,
	output logic [st_glue_pkg::ADDR_W-1:0] rom_addr_o,
	output logic                           viking_active_o,
	output logic [14:0]                    audio_l_o,
	output logic [14:0]                    audio_r_o
);

	st_glue_pkg::cfg_t cfg;	// one cycle behind ctrl_i

	sys_config u_sys_config (
		.clk_32 (clk_32),
		.xsint  (xsint),
		.ctrl_i (ctrl_i),
		.cfg_o  (cfg)
	);

	sdram_arbiter u_sdram_arbiter (
		.clk_32          (clk_32),
		.xsint           (xsint),
		.cfg_i           (cfg),
		.slot_i          (slot_i),
		.slot_en_i       (slot_en_i),
		.chip_req_i      (chip_req_i),
		.bm_i            (bm_i),
		.dl_i            (dl_i),
		.dl_valid_i      (dl_valid_i),
		.download_i      (download_i),
		.vik_read_i      (vik_read_i),
		.vik_addr_i      (vik_addr_i),
		.viking_active_i (viking_active_o),	// video slots go to the card
		.cpu_addr_i      (cpu_addr_i),
		.rom2_sel_i      (rom2_sel_i),
		.dl_ready_o      (dl_ready_o),
		.ram_req_o       (ram_req_o),
		.rom_addr_o      (rom_addr_o)
	);

	viking_detect #(
		.VIKING_CNT_W (VIKING_CNT_W)
	) u_viking_detect (
		.clk_32          (clk_32),
		.xsint           (xsint),
		.cfg_i           (cfg),
		.slot_en_i       (slot_en_i),
		.cpu_as_i        (cpu_as_i),
		.cpu_addr_i      (cpu_addr_i),
		.viking_active_o (viking_active_o)
	);

	audio_mix u_audio_mix (
		.clk_32    (clk_32),
		.xsint     (xsint),
		.cfg_i     (cfg),
		.ym_i      (ym_i),
		.ste_l_i   (ste_l_i),
		.ste_r_i   (ste_r_i),
		.audio_l_o (audio_l_o),
		.audio_r_o (audio_r_o)
	);

endmodule

//--- verif/st_glue_sva.sv
// concurrent checks on the sdram arbiter download handshake and request strobes
`timescale 1ns/1ps

module st_glue_sva (
	input logic                   clk_32,
	input logic                   xsint,
	input st_glue_pkg::bus_slot_e slot_i,
	input logic                   slot_en_i,
	input logic                   download_i,
	input logic                   dl_ready_o,
	input st_glue_pkg::ram_req_t  ram_req_o
);

	int fail_cnt = 0;	// failed assertions so far

	// ready only on a cpu slot during a download
	ready_in_cpu_slot: assert property (@(posedge clk_32) disable iff (!xsint)
		dl_ready_o |-> (slot_en_i && slot_i == st_glue_pkg::SLOT_CPU && download_i))
		else begin
			fail_cnt++;
			$error("dl_ready_o high outside a cpu download slot");
		end

	oe_we_exclusive: assert property (@(posedge clk_32) disable iff (!xsint)
		!(ram_req_o.oe && ram_req_o.we))
		else begin
			fail_cnt++;
			$error("ram_req_o has oe and we set together");
		end

	// strobes only follow a slot cycle
	idle_after_no_slot: assert property (@(posedge clk_32) disable iff (!xsint)
		!slot_en_i |=> !(ram_req_o.oe || ram_req_o.we))
		else begin
			fail_cnt++;
			$error("ram_req_o strobe without a slot the cycle before");
		end

endmodule

//--- verif/tb_clk_gen.sv
// testbench clock and reset source with a restart input
`timescale 1ns/1ps

module tb_clk_gen #(
	parameter int HALF_NS    = 10,	// 20 ns period
	parameter int RST_CYCLES = 5
) (
	input  logic restart_i,	// pulse for another reset
	output logic clk_32,
	output logic xsint
);

	initial clk_32 = 1'b0;
	always #(HALF_NS) clk_32 = ~clk_32;

	initial begin
		xsint = 1'b0;
		forever begin
			repeat (RST_CYCLES) @(posedge clk_32);
			@(negedge clk_32);
			xsint = 1'b1;	// release away from the active edge
			@(posedge restart_i);
			xsint = 1'b0;
		end
	end

endmodule

//--- verif/tb_top.sv
// testbench top with clock, dut, lfsr stimulus, reference model, compare tasks and verdict
`timescale 1ns/1ps

module tb_top;

	localparam int CNT_MAX  = 255;	// 8 bit viking counter full
	localparam int DL_WORDS = 24;
	localparam int WAIT_MAX = 200;	// slots before a wait gives up

	logic                           clk_32;
	logic                           xsint;
	logic                           restart;
	logic [31:0]                    ctrl;
	st_glue_pkg::bus_slot_e         slot;
	logic                           slot_en;
	st_glue_pkg::chip_req_t         chip_req;
	st_glue_pkg::bm_req_t           bm;
	st_glue_pkg::dl_word_t          dl;
	logic                           dl_valid;
	logic                           download;
	logic                           dl_ready;
	logic                           cpu_as;
	logic [st_glue_pkg::ADDR_W-1:0] cpu_addr;
	logic                           rom2_sel;
	logic                           vik_read;
	logic [st_glue_pkg::ADDR_W-1:0] vik_addr;
	st_glue_pkg::ym_chan_t          ym;
	logic [7:0]                     ste_l;
	logic [7:0]                     ste_r;
	st_glue_pkg::ram_req_t          ram_req;
	logic [st_glue_pkg::ADDR_W-1:0] rom_addr;
	logic                           viking_active;
	logic [14:0]                    audio_l;
	logic [14:0]                    audio_r;

	logic [31:0] lfsr_q;
	logic [1:0]  slot_idx;	// pre, cpu, video in turn
	logic        tos_m;	// model of the tos flag
	int          vik_cnt_m;
	logic        vik_act_m;

	tb_clk_gen u_clk_gen (
		.restart_i (restart),
		.clk_32    (clk_32),
		.xsint     (xsint)
	);

	st_glue_top #(
		.VIKING_CNT_W (8)
	) DUT (
		.clk_32          (clk_32),
		.xsint           (xsint),
		.ctrl_i          (ctrl),
		.slot_i          (slot),
		.slot_en_i       (slot_en),
		.chip_req_i      (chip_req),
		.bm_i            (bm),
		.dl_i            (dl),
		.dl_valid_i      (dl_valid),
		.download_i      (download),
		.dl_ready_o      (dl_ready),
		.cpu_as_i        (cpu_as),
		.cpu_addr_i      (cpu_addr),
		.rom2_sel_i      (rom2_sel),
		.vik_read_i      (vik_read),
		.vik_addr_i      (vik_addr),
		.ym_i            (ym),
		.ste_l_i         (ste_l),
		.ste_r_i         (ste_r),
		.ram_req_o       (ram_req),
		.rom_addr_o      (rom_addr),
		.viking_active_o (viking_active),
		.audio_l_o       (audio_l),
		.audio_r_o       (audio_r)
	);

	bind sdram_arbiter st_glue_sva u_sva (.*);

	// galois lfsr stepped once per bit
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr_q[0]};
			lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h80200003) : (lfsr_q >> 1);
		end
		return v;
	endfunction

	function automatic logic rand_bit();
		return 1'(rand_bits(1));
	endfunction

	task automatic stop_on_error();
		$display("FAIL: see errors above");
		$fatal(1);
	endtask

	task automatic check_bit(input string name, input logic exp, got);
		if (got !== exp) begin
			$display("ERR %0t %s exp %b got %b", $time, name, exp, got);
			stop_on_error();
		end
	endtask

	task automatic check_addr(input string name, input logic [st_glue_pkg::ADDR_W-1:0] exp, got);
		if (got !== exp) begin
			$display("ERR %0t %s exp %h got %h", $time, name, exp, got);
			stop_on_error();
		end
	endtask

	task automatic check_audio(input string name, input logic [14:0] exp, got);
		if (got !== exp) begin
			$display("ERR %0t %s exp %h got %h", $time, name, exp, got);
			stop_on_error();
		end
	endtask

	// lvl 0 strobes and data, 1 adds addr, 2 adds byte strobes
	task automatic check_req(input st_glue_pkg::ram_req_t exp, got, input int lvl);
		logic bad;
		bad = (got.oe !== exp.oe) || (got.we !== exp.we) || (got.din !== exp.din);
		if (lvl > 0 && got.addr !== exp.addr)
			bad = 1'b1;
		if (lvl > 1 && (got.uds !== exp.uds || got.lds !== exp.lds))
			bad = 1'b1;
		if (bad) begin
			$display("ERR %0t ram_req_o exp %h got %h", $time, exp, got);
			stop_on_error();
		end
	endtask

	function automatic logic viking_enabled();
		return (ctrl[28] && ctrl[3:1] <= 3'd4) || (ctrl[23] && ctrl[24]);
	endfunction

	function automatic logic [5:0] viking_base();
		return (ctrl[23] && ctrl[24]) ? st_glue_pkg::VIKING_BASE_HI : st_glue_pkg::VIKING_BASE_LO;
	endfunction

	// expected request for the slot now on the bus
	function automatic st_glue_pkg::ram_req_t model_req(input logic fire, output int lvl);
		st_glue_pkg::ram_req_t r;
		logic [23:0]           a;
		logic                  ok;
		a = {chip_req.addr, 1'b0};	// byte address
		case (ctrl[3:1])
			3'd0:    ok = a < 24'h080000;
			3'd1:    ok = a < 24'h100000;
			3'd2:    ok = a < 24'h200000;
			3'd3:    ok = a < 24'h400000;
			3'd4:    ok = a < 24'h800000;
			default: ok = (a[23:21] != 3'b111);	// 14m with io space on top
		endcase
		r.addr = chip_req.addr;
		r.oe   = chip_req.oe && ok && (a != 24'd0);
		r.we   = chip_req.we && ok;
		r.uds  = chip_req.uds;
		r.lds  = chip_req.lds;
		r.din  = download ? dl.data : (bm.has_bus ? bm.data : chip_req.din);
		lvl    = 2;
		if (slot == st_glue_pkg::SLOT_CPU && download) begin
			r.addr = dl.addr;
			r.oe   = 1'b0;
			r.we   = fire;
			r.uds  = 1'b1;
			r.lds  = 1'b1;
		end else if (slot == st_glue_pkg::SLOT_CPU && bm.has_bus) begin
			r.addr = bm.addr;
			r.oe   = bm.read;
			r.we   = bm.write;
			r.uds  = 1'b1;
			r.lds  = 1'b1;
		end else if (slot == st_glue_pkg::SLOT_VIDEO && vik_act_m && vik_read) begin
			r.addr = vik_addr;
			r.oe   = 1'b1;
			r.we   = 1'b0;
			lvl    = 1;
		end
		if (!r.oe && !r.we)
			lvl = 0;
		return r;
	endfunction

	function automatic logic [14:0] mix_model(input int ym_sum, input logic [7:0] smp);
		logic [9:0] y;
		logic [7:0] d;
		y = 10'((ym_sum - 512) & 1023);
		d = 8'((int'(smp) - 128) & 255);
		return 15'({y[9], y, y[9:6]} + {d[7], d, d[7:2]});
	endfunction

	task automatic set_ctrl(input logic [31:0] word);
		ctrl = word;
		@(negedge clk_32);	// cfg follows a clock later
	endtask

	task automatic wait_reset();
		int n;
		n = 0;
		@(negedge clk_32);
		while (xsint !== 1'b1 && n < 20) begin
			@(negedge clk_32);
			n++;
		end
		if (xsint !== 1'b1) begin
			$display("reset was never released");
			stop_on_error();
		end
		@(negedge clk_32);
	endtask

	task automatic check_rom(input int n);
		logic [22:0] exp;
		repeat (n) begin
			cpu_addr = 23'(rand_bits(23));
			rom2_sel = rand_bit();
			#1;
			exp = cpu_addr;
			if (rom2_sel)
				exp[22:17] = tos_m ? 6'b111111 : 6'b111000;	// fc or e0 image
			check_addr("rom_addr_o", exp, rom_addr);
			@(negedge clk_32);
		end
		rom2_sel = 1'b0;
	endtask

	task automatic check_reset_state();
		check_bit("ram_req_o.oe", 1'b0, ram_req.oe);
		check_bit("ram_req_o.we", 1'b0, ram_req.we);
		check_bit("viking_active_o", 1'b0, viking_active);
		check_audio("audio_l_o", 15'd0, audio_l);
		check_audio("audio_r_o", 15'd0, audio_r);
		check_rom(2);	// tos flag clear
	endtask

	task automatic rand_traffic(input logic with_bm);
		logic [1:0] op;
		chip_req.addr = 23'(rand_bits(23) >> rand_bits(3));	// spread over the windows
		if (rand_bits(3) == 0)
			chip_req.addr = '0;
		chip_req.din = 16'(rand_bits(16));
		op           = 2'(rand_bits(2));
		chip_req.oe  = (op == 2'd1);
		chip_req.we  = op[1];
		chip_req.uds = rand_bit();
		chip_req.lds = rand_bit();
		bm.addr      = 23'(rand_bits(23));
		bm.data      = 16'(rand_bits(16));
		bm.has_bus   = with_bm & rand_bit();
		bm.write     = rand_bit();
		bm.read      = ~bm.write;
		vik_read     = rand_bit();
		vik_addr     = 23'(rand_bits(23));
	endtask

	// strobe now, request checked next cycle, four cycles per slot
	task automatic run_slot(output logic fire);
		st_glue_pkg::ram_req_t exp;
		int                    lvl;
		logic                  hit;
		slot     = st_glue_pkg::bus_slot_e'(slot_idx);
		slot_idx = (slot_idx == 2'd2) ? 2'd0 : slot_idx + 2'd1;
		slot_en  = 1'b1;
		#1;
		check_bit("dl_ready_o", download && slot == st_glue_pkg::SLOT_CPU, dl_ready);
		fire = dl_valid && download && slot == st_glue_pkg::SLOT_CPU;
		exp  = model_req(fire, lvl);
		hit  = cpu_as && viking_enabled() && cpu_addr[22:17] == viking_base();
		if (fire && dl.addr[22:17] == 6'h3f)
			tos_m = 1'b1;
		else if (fire && dl.addr[22:19] == 4'he)
			tos_m = 1'b0;
		@(negedge clk_32);
		slot_en = 1'b0;
		check_req(exp, ram_req, lvl);
		if (hit && vik_cnt_m < CNT_MAX)
			vik_cnt_m++;
		if (vik_cnt_m == CNT_MAX)
			vik_act_m = 1'b1;
		repeat (3) @(negedge clk_32);
		check_bit("viking_active_o", vik_act_m, viking_active);
	endtask

	// source holds the word until the arbiter takes it
	task automatic send_word(input logic [22:0] addr, input logic [15:0] data);
		logic fire;
		int   n;
		dl.addr  = addr;
		dl.data  = data;
		dl_valid = 1'b1;
		fire     = 1'b0;
		n        = 0;
		while (!fire && n < WAIT_MAX) begin
			rand_traffic(1'b1);	// blitter competes
			run_slot(fire);
			n++;
		end
		dl_valid = 1'b0;
		if (!fire) begin
			$display("download word for %h was never accepted", addr);
			stop_on_error();
		end
	endtask

	task automatic viking_run(input logic [31:0] word);
		logic fire;
		set_ctrl(word);
		cpu_as = 1'b1;
		for (int i = 0; i < 3 * (CNT_MAX + 8); i++) begin
			rand_traffic(1'b0);
			cpu_addr = {viking_base(), 17'(rand_bits(17))};
			if (rand_bits(3) == 0)
				cpu_addr = 23'(rand_bits(23));	// stray access
			run_slot(fire);
		end
		cpu_as = 1'b0;
		check_bit("viking_active_o", 1'b1, viking_active);
	endtask

	task automatic audio_run(input logic stereo);
		int sum_l;
		int sum_r;
		set_ctrl(stereo ? 32'h0040_0000 : 32'h0);
		repeat (40) begin
			ym    = 24'(rand_bits(24));
			ste_l = 8'(rand_bits(8));
			ste_r = 8'(rand_bits(8));
			sum_l = int'(ym.a) + int'(ym.b) + (stereo ? 0 : int'(ym.c));
			sum_r = int'(ym.c) + int'(ym.b) + (stereo ? 0 : int'(ym.a));
			@(negedge clk_32);
			check_audio("audio_l_o", mix_model(sum_l, ste_l), audio_l);
			check_audio("audio_r_o", mix_model(sum_r, ste_r), audio_r);
		end
	endtask

	initial begin
		logic fire;
		restart   = 1'b0;
		ctrl      = '0;
		slot      = st_glue_pkg::SLOT_PRE;
		slot_en   = 1'b0;
		chip_req  = '0;
		bm        = '0;
		dl        = '0;
		dl_valid  = 1'b0;
		download  = 1'b0;
		cpu_as    = 1'b0;
		cpu_addr  = '0;
		rom2_sel  = 1'b0;
		vik_read  = 1'b0;
		vik_addr  = '0;
		ym        = '0;
		ste_l     = '0;
		ste_r     = '0;
		lfsr_q    = 32'hbf83;
		slot_idx  = 2'd0;
		tos_m     = 1'b0;
		vik_cnt_m = 0;
		vik_act_m = 1'b0;
		repeat (2) @(negedge clk_32);
		check_reset_state();	// still inside reset
		wait_reset();

		// window rule per size code, chipset only
		for (int sz = 0; sz < 6; sz++) begin
			set_ctrl({28'h0, 3'(sz), 1'b0});
			repeat (30) begin
				rand_traffic(1'b0);
				run_slot(fire);
			end
		end

		// downloads with gaps and a busy blitter
		download = 1'b1;
		for (int w = 0; w < DL_WORDS; w++) begin
			repeat (rand_bits(2)) begin
				rand_traffic(1'b1);
				run_slot(fire);
			end
			send_word(23'(rand_bits(23)), 16'(rand_bits(16)));
		end

		// tos image size from the download address
		send_word(23'h7e0000, 16'h602e);	// fc0000
		check_rom(16);
		send_word(23'h700000, 16'h602e);	// e00000
		check_rom(16);
		download = 1'b0;

		repeat (40) begin
			rand_traffic(1'b1);	// blitter against chipset
			run_slot(fire);
		end

		viking_run(32'h1000_0006);	// low base, 4m
		restart = 1'b1;
		@(negedge clk_32);
		restart   = 1'b0;
		tos_m     = 1'b0;
		vik_cnt_m = 0;
		vik_act_m = 1'b0;
		check_reset_state();
		wait_reset();
		viking_run(32'h0180_000a);	// steroids, high base, 14m

		audio_run(1'b0);
		audio_run(1'b1);

		if (DUT.u_sdram_arbiter.u_sva.fail_cnt == 0) begin
			$display("PASS: all tests");
			$finish;
		end else begin
			$display("assertions failed: %0d", DUT.u_sdram_arbiter.u_sva.fail_cnt);
			stop_on_error();
		end
	end

endmodule

//--- files.f
logic/st_glue_pkg.sv
logic/sys_config.sv
logic/sdram_arbiter.sv
logic/viking_detect.sv
logic/audio_mix.sv
logic/st_glue_top.sv
verif/st_glue_sva.sv
verif/tb_clk_gen.sv
verif/tb_top.sv

//--- run.sh
#!/bin/sh
# compile with verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal -f files.f --top-module tb_top --Mdir obj_dir -o sim_tb
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

out=$(./obj_dir/sim_tb 2>&1)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -qx "PASS: all tests"; then
	exit 0
fi
echo "pass line not found in simulation output"
exit 1
